// ==== logic/bit_receiver.sv ====
`timescale 1ns/1ns
`default_nettype none

module bit_receiver (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           start,
	input  wire           bin0,
	input  wire           bin1,
	output pkt_pkg::pkt_t rx_pkt,
	output logic          rx_valid
);

	pkt_pkg::rx_state_t state;

	logic [1:0] arm_cnt; // start-low cycles seen so far
	logic [1:0] bit_cnt; // bits taken in this packet
	logic [pkt_pkg::PKT_BITS-1:0] shift_q;
	logic last_bit; // fourth bit sampled last edge

	logic btn_press;
	logic btn_release;
	logic press_bit;

	// exactly one button low counts as a press
	assign btn_press   = (state == pkt_pkg::wait_press) && (bin0 ^ bin1);
	assign btn_release = bin0 && bin1;
	assign press_bit   = ~bin1; // bin1 low keys a 1

	assign rx_pkt = pkt_pkg::pkt_t'(shift_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= pkt_pkg::idle;
			arm_cnt  <= '0;
			bit_cnt  <= '0;
			last_bit <= 1'b0;
			rx_valid <= 1'b0;
		end else begin
			last_bit <= 1'b0;
			rx_valid <= last_bit; // packet pulse one edge after last press

			case (state)
				pkt_pkg::idle: begin
					if (!start) begin
						if (arm_cnt == 2'(pkt_pkg::ARM_COUNT - 1)) begin
							arm_cnt <= '0;
							bit_cnt <= '0;
							state   <= pkt_pkg::wait_press;
						end else begin
							arm_cnt <= arm_cnt + 2'd1;
						end
					end
				end

				pkt_pkg::wait_press: begin
					if (btn_press) begin
						bit_cnt <= bit_cnt + 2'd1;
						if (bit_cnt == 2'(pkt_pkg::PKT_BITS - 1)) begin
							last_bit <= 1'b1;
							state    <= pkt_pkg::idle; // disarm, start must be seen again
						end else begin
							state <= pkt_pkg::wait_release;
						end
					end
				end

				pkt_pkg::wait_release: begin
					if (btn_release) begin
						state <= pkt_pkg::wait_press;
					end
				end

				default: begin
					state <= pkt_pkg::idle;
				end
			endcase
		end
	end

	// first bit ends up as msb
	always_ff @(posedge clk) begin
		if (btn_press) begin
			shift_q <= {shift_q[pkt_pkg::PKT_BITS-2:0], press_bit};
		end
	end

endmodule

`default_nettype wire

// ==== logic/pkt_buffer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_buffer_top (
	input  wire                                                clk,
	input  wire                                                rst_n,
	input  wire                                                start,
	input  wire                                                bin0,
	input  wire                                                bin1,
	output wire pkt_pkg::pkt_t                                 read_item,
	output wire                                                read_valid,
	output wire                                                read_none,
	output wire pkt_pkg::queue_stat_t [pkt_pkg::NUM_QUEUES-1:0] q_stat
);

	wire pkt_pkg::pkt_t rx_pkt;
	wire                rx_valid;

	wire pkt_pkg::pkt_t [pkt_pkg::NUM_QUEUES-1:0] head;
	wire [pkt_pkg::NUM_QUEUES-1:0]                pop;

	bit_receiver rx_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.bin0     (bin0),
		.bin1     (bin1),
		.rx_pkt   (rx_pkt),
		.rx_valid (rx_valid)
	);

	// every queue sees the strobe, only the addressed one takes it
	for (genvar g = 0; g < pkt_pkg::NUM_QUEUES; g++) begin : g_queue
		pkt_queue #(
			.QUEUE_ID (pkt_pkg::qid_t'(g))
		) queue_i (
			.clk      (clk),
			.rst_n    (rst_n),
			.rx_pkt   (rx_pkt),
			.rx_valid (rx_valid),
			.pop      (pop[g]),
			.head     (head[g]),
			.stat     (q_stat[g])
		);
	end

	readout_arbiter arb_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.head       (head),
		.stat       (q_stat),
		.pop        (pop),
		.read_item  (read_item),
		.read_valid (read_valid),
		.read_none  (read_none)
	);

endmodule

`default_nettype wire

// ==== logic/pkt_pkg.sv ====
`default_nettype none

package pkt_pkg;

	// buffer geometry
	localparam int NUM_QUEUES  = 4;
	localparam int QUEUE_DEPTH = 6;

	// receiver
	localparam int ARM_COUNT = 3; // start-low cycles, need not be consecutive
	localparam int PKT_BITS  = 4;

	// readout arbiter
	localparam int READ_PERIOD = 64; // clocks between firings
	localparam int Q3_THRESH   = 3;
	localparam int Q2_THRESH   = 4;
	localparam int Q1_THRESH   = 5;

	localparam int DROP_MAX = 127; // drop counter saturates here

	typedef logic [1:0] qid_t;
	typedef logic [1:0] payload_t;
	typedef logic [2:0] level_t; // 0 to 6
	typedef logic [6:0] drop_cnt_t;
	typedef logic [5:0] period_cnt_t;

	// qid sits in the top two bits, as keyed in
	typedef struct packed {
		qid_t     qid;
		payload_t payload;
	} pkt_t;

	typedef struct packed {
		level_t    level;
		drop_cnt_t drops;
	} queue_stat_t;

	typedef enum logic [1:0] {
		idle,
		wait_press,
		wait_release
	} rx_state_t;

endpackage

`default_nettype wire

// ==== logic/pkt_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module pkt_queue #(
	parameter pkt_pkg::qid_t QUEUE_ID = '0
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire pkt_pkg::pkt_t   rx_pkt,
	input  wire                  rx_valid,
	input  wire                  pop,
	output pkt_pkg::pkt_t        head,
	output pkt_pkg::queue_stat_t stat
);

	// slot 0 is newest, slot level-1 the oldest
	pkt_pkg::payload_t slot [pkt_pkg::QUEUE_DEPTH];

	pkt_pkg::level_t   level;
	pkt_pkg::drop_cnt_t drops;
	pkt_pkg::level_t   oldest;

	logic push;
	logic do_pop;
	logic full;

	assign push   = rx_valid && (rx_pkt.qid == QUEUE_ID);
	assign do_pop = pop && (level != '0);
	assign full   = (level == pkt_pkg::level_t'(pkt_pkg::QUEUE_DEPTH));
	assign oldest = (level == '0) ? '0 : level - pkt_pkg::level_t'(1);

	// shift toward the oldest end, slot 5 falls off when full
	always_ff @(posedge clk) begin
		if (push) begin
			slot[0] <= rx_pkt.payload;
			for (int i = 1; i < pkt_pkg::QUEUE_DEPTH; i++) begin
				slot[i] <= slot[i-1];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level <= '0;
			drops <= '0;
		end else begin
			if (push && !do_pop) begin
				if (full) begin
					if (drops != pkt_pkg::drop_cnt_t'(pkt_pkg::DROP_MAX)) begin
						drops <= drops + pkt_pkg::drop_cnt_t'(1); // oldest lost
					end
				end else begin
					level <= level + pkt_pkg::level_t'(1);
				end
			end else if (do_pop && !push) begin
				level <= level - pkt_pkg::level_t'(1);
			end
			// push with pop: oldest popped, new one in, level holds
		end
	end

	assign head = '{qid: QUEUE_ID, payload: slot[oldest]};
	assign stat = '{level: level, drops: drops};

endmodule

`default_nettype wire

// ==== logic/readout_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module readout_arbiter (
	input  wire                                                clk,
	input  wire                                                rst_n,
	input  wire pkt_pkg::pkt_t [pkt_pkg::NUM_QUEUES-1:0]        head,
	input  wire pkt_pkg::queue_stat_t [pkt_pkg::NUM_QUEUES-1:0] stat,
	output logic [pkt_pkg::NUM_QUEUES-1:0]                     pop,
	output pkt_pkg::pkt_t                                      read_item,
	output logic                                               read_valid,
	output logic                                               read_none
);

	pkt_pkg::period_cnt_t period_cnt;
	logic fire;

	pkt_pkg::level_t lvl [pkt_pkg::NUM_QUEUES];

	logic          grant_valid;
	pkt_pkg::qid_t grant_id;

	assign fire = (period_cnt == pkt_pkg::period_cnt_t'(pkt_pkg::READ_PERIOD - 1));

	always_comb begin
		for (int i = 0; i < pkt_pkg::NUM_QUEUES; i++) begin
			lvl[i] = stat[i].level;
		end
	end

	// weighted grant, then plain 0..3 order on whatever is non-empty
	always_comb begin
		grant_valid = 1'b1;
		grant_id    = 2'd0;
		if (lvl[3] >= pkt_pkg::level_t'(pkt_pkg::Q3_THRESH)) begin
			grant_id = 2'd3;
		end else if (lvl[2] >= pkt_pkg::level_t'(pkt_pkg::Q2_THRESH)) begin
			grant_id = 2'd2;
		end else if (lvl[1] >= pkt_pkg::level_t'(pkt_pkg::Q1_THRESH)) begin
			grant_id = 2'd1;
		end else if (lvl[0] != '0) begin
			grant_id = 2'd0;
		end else if (lvl[1] != '0) begin
			grant_id = 2'd1;
		end else if (lvl[2] != '0) begin
			grant_id = 2'd2;
		end else if (lvl[3] != '0) begin
			grant_id = 2'd3;
		end else begin
			grant_valid = 1'b0; // all empty
		end
	end

	// pop lands on the same edge that registers the readout
	always_comb begin
		pop = '0;
		if (fire && grant_valid) begin
			pop[grant_id] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			period_cnt <= '0;
			read_valid <= 1'b0;
			read_none  <= 1'b0;
		end else begin
			if (fire) begin
				period_cnt <= '0;
			end else begin
				period_cnt <= period_cnt + pkt_pkg::period_cnt_t'(1);
			end

			read_valid <= fire && grant_valid;

			if (fire) begin
				read_none <= !grant_valid; // level, held until next firing
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire && grant_valid) begin
			read_item <= head[grant_id];
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
logic/pkt_pkg.sv
logic/bit_receiver.sv
logic/pkt_queue.sv
logic/readout_arbiter.sv
logic/pkt_buffer_top.sv
verif/tb_pkt_buffer.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the packet buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_pkt_buffer -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST OK$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== verif/tb_pkt_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pkt_buffer;

	localparam int CLK_PERIOD  = 100;
	localparam int NUM_RAND    = 30;
	localparam int PKT_CYCLES  = 10; // 3 arm cycles plus 7 press and release cycles
	localparam int DRAIN_FIRES = pkt_pkg::NUM_QUEUES * pkt_pkg::QUEUE_DEPTH + 2;
	localparam int WATCHDOG_CYCLES = (32 + NUM_RAND) * PKT_CYCLES
		+ (4 * DRAIN_FIRES + 16) * pkt_pkg::READ_PERIOD + 1000;

	logic clk;
	logic rst_n;
	logic start;
	logic bin0;
	logic bin1;
	wire pkt_pkg::pkt_t read_item;
	wire read_valid;
	wire read_none;
	wire pkt_pkg::queue_stat_t [pkt_pkg::NUM_QUEUES-1:0] q_stat;

	pkt_pkg::payload_t  mq [pkt_pkg::NUM_QUEUES][$]; // oldest at front
	pkt_pkg::drop_cnt_t md [pkt_pkg::NUM_QUEUES];
	int                 pend_edge [$]; // edge where a sent packet lands
	pkt_pkg::pkt_t      pend_pkt [$];
	int                 edge_cnt = 0; // posedges since reset release
	logic               exp_valid = 1'b0;
	logic               exp_none = 1'b0;
	pkt_pkg::pkt_t      exp_item;

	int    seed = 32'h3737_9534;
	string test_name = "reset";

	pkt_buffer_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.bin0       (bin0),
		.bin1       (bin1),
		.read_item  (read_item),
		.read_valid (read_valid),
		.read_none  (read_none),
		.q_stat     (q_stat)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic pkt_pkg::pkt_t make_pkt(input pkt_pkg::qid_t q,
		input pkt_pkg::payload_t d);
		pkt_pkg::pkt_t p;
		p.qid     = q;
		p.payload = d;
		return p;
	endfunction

	function automatic pkt_pkg::queue_stat_t model_stat(input int q);
		pkt_pkg::queue_stat_t s;
		s.level = pkt_pkg::level_t'(mq[q].size());
		s.drops = md[q];
		return s;
	endfunction

	function automatic logic model_empty();
		return (mq[0].size() + mq[1].size() + mq[2].size() + mq[3].size()) == 0;
	endfunction

	// weighted grant, -1 when nothing to read
	function automatic int pick_queue(input int lv0, input int lv1, input int lv2, input int lv3);
		if (lv3 >= pkt_pkg::Q3_THRESH) return 3;
		if (lv2 >= pkt_pkg::Q2_THRESH) return 2;
		if (lv1 >= pkt_pkg::Q1_THRESH) return 1;
		if (lv0 > 0) return 0;
		if (lv1 > 0) return 1;
		if (lv2 > 0) return 2;
		if (lv3 > 0) return 3;
		return -1;
	endfunction

	function automatic void model_push(input pkt_pkg::pkt_t p);
		int q;
		q = int'(p.qid);
		if (mq[q].size() == pkt_pkg::QUEUE_DEPTH) begin
			mq[q].delete(0); // oldest lost
			if (md[q] != pkt_pkg::drop_cnt_t'(pkt_pkg::DROP_MAX)) md[q] = md[q] + 7'd1;
		end
		mq[q].push_back(p.payload);
	endfunction

	task automatic check_pkt(input string name, input pkt_pkg::pkt_t exp,
		input pkt_pkg::pkt_t act);
		if (act !== exp) begin
			$display("FAIL %s %s: expected qid %0d payload %0d, actual qid %0d payload %0d",
				test_name, name, exp.qid, exp.payload, act.qid, act.payload);
			$display("TEST FAILED");
			$fatal(1, "packet mismatch");
		end
	endtask

	task automatic check_stat(input string name, input pkt_pkg::queue_stat_t exp,
		input pkt_pkg::queue_stat_t act);
		if (act !== exp) begin
			$display("FAIL %s %s: expected level %0d drops %0d, actual level %0d drops %0d",
				test_name, name, exp.level, exp.drops, act.level, act.drops);
			$display("TEST FAILED");
			$fatal(1, "queue stat mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s %s: expected %b, actual %b", test_name, name, exp, act);
			$display("TEST FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	// entered and left on a falling edge
	task automatic send_packet(input pkt_pkg::pkt_t p);
		logic [pkt_pkg::PKT_BITS-1:0] bits;
		int i;
		bits  = p;
		start = 1'b0;
		repeat (pkt_pkg::ARM_COUNT) @(negedge clk);
		start = 1'b1;
		for (i = pkt_pkg::PKT_BITS - 1; i >= 0; i--) begin
			bin0 = bits[i]; // bin0 low keys a 0
			bin1 = ~bits[i];
			if (i == 0) begin
				pend_edge.push_back(edge_cnt + 3); // sample, rx pulse, then level
				pend_pkt.push_back(p);
			end
			@(negedge clk);
			bin0 = 1'b1;
			bin1 = 1'b1;
			if (i != 0) @(negedge clk);
		end
	endtask

	// n random payloads to queue q, returns the payload of packet idx
	task automatic send_burst(input pkt_pkg::qid_t q, input int n, input int idx,
		output pkt_pkg::payload_t pay);
		logic [31:0] r;
		int k;
		for (k = 0; k < n; k++) begin
			r = $random(seed);
			if (k == idx) pay = r[1:0];
			send_packet(make_pkt(q, r[1:0]));
		end
	endtask

	task automatic wait_fire();
		do begin
			@(negedge clk);
		end while (edge_cnt % pkt_pkg::READ_PERIOD != 0);
	endtask

	task automatic wait_pushes();
		while (pend_edge.size() != 0) @(negedge clk);
	endtask

	task automatic drain_queues();
		while (pend_edge.size() != 0 || !model_empty()) wait_fire();
	endtask

	initial begin : model_proc
		int g;
		for (g = 0; g < pkt_pkg::NUM_QUEUES; g++) md[g] = '0;
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clk);
			edge_cnt++;
			exp_valid = 1'b0;
			if (edge_cnt % pkt_pkg::READ_PERIOD == 0) begin
				g = pick_queue(mq[0].size(), mq[1].size(), mq[2].size(), mq[3].size());
				if (g < 0) begin
					exp_none = 1'b1;
				end else begin
					exp_item  = make_pkt(pkt_pkg::qid_t'(g), mq[g].pop_front());
					exp_valid = 1'b1;
					exp_none  = 1'b0;
				end
			end
			// pop before push on a shared edge
			while (pend_edge.size() != 0 && pend_edge[0] <= edge_cnt) begin
				model_push(pend_pkt.pop_front());
				pend_edge.delete(0);
			end
		end
	end

	initial begin : compare_proc
		int q;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk);
			check_flag("read_valid", exp_valid, read_valid);
			if (exp_valid) check_pkt("read_item", exp_item, read_item);
			check_flag("read_none", exp_none, read_none);
			for (q = 0; q < pkt_pkg::NUM_QUEUES; q++) begin
				check_stat($sformatf("q%0d stat", q), model_stat(q), q_stat[q]);
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		pkt_pkg::queue_stat_t want;
		pkt_pkg::payload_t    pay0, pay1, pay2, pay3;
		pkt_pkg::pkt_t        p;
		logic [31:0]          r;
		int                   q;
		int                   k;

		rst_n = 1'b0;
		start = 1'b1;
		bin0  = 1'b1;
		bin1  = 1'b1;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		check_flag("read_valid", 1'b0, read_valid);
		check_flag("read_none", 1'b0, read_none);
		want = '0;
		for (q = 0; q < pkt_pkg::NUM_QUEUES; q++) check_stat("after reset", want, q_stat[q]);

		test_name = "unarmed_presses";
		for (k = 0; k < 4; k++) begin
			bin0 = k[0];
			bin1 = ~k[0];
			@(negedge clk);
			bin0 = 1'b1;
			bin1 = 1'b1;
			@(negedge clk);
		end
		repeat (2) @(negedge clk); // a stray packet would have landed by now
		for (q = 0; q < pkt_pkg::NUM_QUEUES; q++) check_stat("no level change", want, q_stat[q]);

		test_name = "single_packet"; // all four land before the first firing
		for (k = 0; k < pkt_pkg::NUM_QUEUES; k++) begin
			r = $random(seed);
			send_packet(make_pkt(pkt_pkg::qid_t'(k), r[1:0]));
			wait_pushes();
			for (q = 0; q < pkt_pkg::NUM_QUEUES; q++) begin
				want.level = (q <= k) ? 3'd1 : 3'd0;
				want.drops = '0;
				check_stat($sformatf("q%0d level", q), want, q_stat[q]);
			end
		end

		test_name = "empty_read";
		drain_queues();
		wait_fire();
		check_flag("none set", 1'b1, read_none);
		check_flag("no valid", 1'b0, read_valid);
		r = $random(seed);
		p = make_pkt(r[3:2], r[1:0]);
		send_packet(p);
		wait_fire();
		check_flag("valid after", 1'b1, read_valid);
		check_flag("none cleared", 1'b0, read_none);
		check_pkt("read after", p, read_item);

		// queue 3 stays at or above its threshold so queue 0 is never granted
		test_name = "overflow";
		drain_queues();
		wait_fire();
		send_burst(2'd3, 6, 0, pay3);
		send_burst(2'd0, 8, 2, pay0);
		wait_pushes();
		want.level = 3'd6;
		want.drops = 7'd2;
		check_stat("q0 full", want, q_stat[0]);
		do begin
			@(negedge clk);
		end while (!(read_valid === 1'b1 && read_item.qid == 2'd0));
		check_pkt("oldest survivor", make_pkt(2'd0, pay0), read_item);

		test_name = "grant_q3";
		drain_queues();
		wait_fire();
		send_burst(2'd0, 1, 0, pay0);
		send_burst(2'd3, 3, 0, pay3);
		wait_fire();
		check_pkt("q3 at 3", make_pkt(2'd3, pay3), read_item);
		test_name = "grant_q2";
		send_burst(2'd2, 4, 0, pay2);
		wait_fire();
		check_pkt("q2 at 4", make_pkt(2'd2, pay2), read_item);
		test_name = "grant_q1";
		send_burst(2'd1, 5, 0, pay1);
		wait_fire();
		check_pkt("q1 at 5", make_pkt(2'd1, pay1), read_item);
		test_name = "grant_order";
		wait_fire();
		check_pkt("q0 first", make_pkt(2'd0, pay0), read_item);
		drain_queues();

		test_name = "random_mix";
		for (k = 0; k < NUM_RAND; k++) begin
			r = $random(seed);
			send_packet(make_pkt(r[3:2], r[1:0]));
		end
		drain_queues();

		test_name = "final_stats";
		for (q = 0; q < pkt_pkg::NUM_QUEUES; q++) begin
			check_stat($sformatf("q%0d final", q), model_stat(q), q_stat[q]);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
